// File: common/correlator_config.svh
// Correlator sizing
// Line count, sample and accumulator widths, lag window and delay range

`ifndef CORRELATOR_CONFIG_SVH
`define CORRELATOR_CONFIG_SVH

// Input lines and sample format
`define NUM_INPUTS 4
`define WORD_WIDTH 2                              // Signed samples

// Lag window, LAG_CROSS*2-1 lags per baseline
`define LAG_CROSS 2
`define NUM_LAGS (`LAG_CROSS * 2 - 1)

// Programmable delay offset
`define DELAY_DEPTH 7
`define DELAY_WIDTH 3

// History length covers the largest offset plus the quadrature tap
`define HIST_DEPTH (`DELAY_DEPTH + `NUM_LAGS + 1)

// Accumulator width, small so that saturation is reachable
`define RESOLUTION 10

// One baseline per unordered line pair
`define NUM_BASELINES (`NUM_INPUTS * (`NUM_INPUTS - 1) / 2)

`endif

// File: common/correlator_pkg.sv
// Correlator types
// Samples, per-line setup, tap windows, accumulators and the dumped frame

`include "correlator_config.svh"

package correlator_pkg;

	// ********************************************************************
	// Input side
	// ********************************************************************

	typedef logic signed [`WORD_WIDTH-1:0] sample_t;

	typedef struct packed {
		logic [`DELAY_WIDTH-1:0] delay;    // Tap offset into the history
		logic mode;                        // Difference mode when set on both lines
	} line_cfg_t;

	// Window one line presents to every baseline it takes part in
	typedef struct packed {
		sample_t [`NUM_LAGS-1:0] re_taps;
		sample_t [`NUM_LAGS-1:0] im_taps;  // Same window one tap later
	} tap_win_t;

	// ********************************************************************
	// Accumulator side
	// ********************************************************************

	typedef logic signed [`RESOLUTION-1:0] acc_t;

	typedef struct packed {
		acc_t re;
		acc_t im;
	} acc_pair_t;

	typedef struct packed {
		acc_pair_t [`NUM_LAGS-1:0] lags;
		logic overflow;                    // Sticky until the next dump
	} baseline_acc_t;

	// Baselines ordered (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	typedef baseline_acc_t [`NUM_BASELINES-1:0] frame_t;

endpackage

// File: src/delay_line.sv
// Per-line delay line
// Shifts in a sample on each strobe and presents the real and quadrature
// tap windows at the programmed offset

`include "correlator_config.svh"

module delay_line (
	input  logic                        pllclk,
	input  logic                        reset,
	input  logic                        smp,
	input  correlator_pkg::sample_t     sample,
	input  logic [`DELAY_WIDTH-1:0]     delay,
	output correlator_pkg::tap_win_t    win
);

	// hist[0] holds the newest sample
	correlator_pkg::sample_t [`HIST_DEPTH-1:0] hist;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			hist <= '0;
		end else if (smp) begin
			hist <= {hist[`HIST_DEPTH-2:0], sample};
		end
	end

	// ********************************************************************
	// Window select
	// ********************************************************************

	// Quadrature window sits one tap further back than the real one
	always_comb begin
		for (int k = 0; k < `NUM_LAGS; k++) begin
			win.re_taps[k] = hist[int'(delay) + k];
			win.im_taps[k] = hist[int'(delay) + k + 1];
		end
	end

endmodule

// File: correlator/baseline_mac.sv
// Baseline multiply/difference accumulator
// Three lags of real and quadrature sums for one line pair, with a
// sticky overflow that freezes the whole baseline until the next dump

`include "correlator_config.svh"

module baseline_mac (
	input  logic                            pllclk,
	input  logic                            reset,
	input  logic                            add_en,
	input  logic                            clr_acc,
	input  correlator_pkg::tap_win_t        win_a,
	input  correlator_pkg::tap_win_t        win_b,
	input  logic                            diff_mode,
	output correlator_pkg::baseline_acc_t   acc
);

	localparam int TERM_W = 2 * `WORD_WIDTH;
	localparam int CENTRE = `LAG_CROSS - 1;
	// One worst-case product short of full scale
	localparam int LIMIT = (1 << (`RESOLUTION - 1)) - 1 - (1 << TERM_W);

	logic signed [TERM_W-1:0] term_re [`NUM_LAGS];
	logic signed [TERM_W-1:0] term_im [`NUM_LAGS];
	logic near_lim;

	// Lag k pairs tap k of line a with the centre tap of line b
	always_comb begin
		for (int k = 0; k < `NUM_LAGS; k++) begin
			if (diff_mode) begin
				term_re[k] = $signed(win_a.re_taps[k]) - $signed(win_b.re_taps[CENTRE]);
				term_im[k] = $signed(win_a.im_taps[k]) - $signed(win_b.im_taps[CENTRE]);
			end else begin
				term_re[k] = $signed(win_a.re_taps[k]) * $signed(win_b.re_taps[CENTRE]);
				term_im[k] = $signed(win_a.im_taps[k]) * $signed(win_b.im_taps[CENTRE]);
			end
		end
	end

	// Headroom check over every sum of the baseline
	always_comb begin
		near_lim = 1'b0;
		for (int k = 0; k < `NUM_LAGS; k++) begin
			if (acc.lags[k].re >= LIMIT || acc.lags[k].re <= -LIMIT)
				near_lim = 1'b1;
			if (acc.lags[k].im >= LIMIT || acc.lags[k].im <= -LIMIT)
				near_lim = 1'b1;
		end
	end

	// ********************************************************************
	// Accumulate, freeze or restart
	// ********************************************************************

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			acc <= '0;
		end else if (clr_acc) begin
			// Restart keeps the term landing on this edge
			acc.overflow <= 1'b0;
			for (int k = 0; k < `NUM_LAGS; k++) begin
				acc.lags[k].re <= add_en ? correlator_pkg::acc_t'(term_re[k]) : '0;
				acc.lags[k].im <= add_en ? correlator_pkg::acc_t'(term_im[k]) : '0;
			end
		end else if (add_en) begin
			if (acc.overflow || near_lim) begin
				acc.overflow <= 1'b1;      // Frozen
			end else begin
				for (int k = 0; k < `NUM_LAGS; k++) begin
					acc.lags[k].re <= acc.lags[k].re + correlator_pkg::acc_t'(term_re[k]);
					acc.lags[k].im <= acc.lags[k].im + correlator_pkg::acc_t'(term_im[k]);
				end
			end
		end
	end

endmodule

// File: correlator/correlator_array.sv
// Baseline array
// One accumulator per line pair, fed from the per-line tap windows and
// clocked by a once-delayed copy of the sample strobe

`include "correlator_config.svh"

module correlator_array (
	input  logic                                            pllclk,
	input  logic                                            reset,
	input  logic                                            smp,
	input  logic                                            clr_acc,
	input  correlator_pkg::tap_win_t  [`NUM_INPUTS-1:0]     wins,
	input  correlator_pkg::line_cfg_t [`NUM_INPUTS-1:0]     line_cfg,
	output correlator_pkg::frame_t                          accs
);

	// Taps settle one cycle after the history shift
	logic add_en;

	always_ff @(posedge pllclk) begin
		if (!reset)
			add_en <= 1'b0;
		else
			add_en <= smp;
	end

	// ********************************************************************
	// Pair enumeration
	// ********************************************************************

	// Index of (a,b) counts the pairs before row a, then the offset in it
	for (genvar a = 0; a < `NUM_INPUTS - 1; a++) begin : g_row
		for (genvar b = a + 1; b < `NUM_INPUTS; b++) begin : g_col
			localparam int IDX = a * (2 * `NUM_INPUTS - a - 1) / 2 + (b - a - 1);

			logic diff_mode;

			assign diff_mode = line_cfg[a].mode & line_cfg[b].mode;

			baseline_mac u_mac (
				.pllclk    (pllclk),
				.reset     (reset),
				.add_en    (add_en),
				.clr_acc   (clr_acc),
				.win_a     (wins[a]),
				.win_b     (wins[b]),
				.diff_mode (diff_mode),
				.acc       (accs[IDX])
			);
		end
	end

endmodule

// File: src/integration_dump.sv
// Integration dump
// Snapshots the live accumulators into the frame register on a dump pulse,
// restarts the integration and flags the new frame for one cycle

module integration_dump (
	input  logic                        pllclk,
	input  logic                        reset,
	input  logic                        dump,
	input  correlator_pkg::frame_t      accs,
	output logic                        clr_acc,
	output correlator_pkg::frame_t      frame,
	output logic                        frame_valid
);

	// Restart lands on the same edge as the snapshot
	assign clr_acc = dump;

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			frame       <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= dump;          // High for the cycle after the dump
			if (dump)
				frame <= accs;            // Held until the next dump
		end
	end

endmodule

// File: src/correlator_top.sv
// Cross-correlator top
// Delay lines per input, the baseline array and the frame dump logic

`include "correlator_config.svh"

module correlator_top (
	input  logic                                            pllclk,
	input  logic                                            reset,
	input  logic                                            smp,
	input  correlator_pkg::sample_t   [`NUM_INPUTS-1:0]     samples,
	input  correlator_pkg::line_cfg_t [`NUM_INPUTS-1:0]     line_cfg,
	input  logic                                            dump,
	output correlator_pkg::frame_t                          frame,
	output logic                                            frame_valid
);

	correlator_pkg::tap_win_t [`NUM_INPUTS-1:0] wins;
	correlator_pkg::frame_t                     accs;
	logic                                       clr_acc;

	// ********************************************************************
	// Input delay lines
	// ********************************************************************

	for (genvar i = 0; i < `NUM_INPUTS; i++) begin : g_line
		delay_line u_delay (
			.pllclk (pllclk),
			.reset  (reset),
			.smp    (smp),
			.sample (samples[i]),
			.delay  (line_cfg[i].delay),
			.win    (wins[i])
		);
	end

	// ********************************************************************
	// Correlation and dump
	// ********************************************************************

	correlator_array u_array (
		.pllclk   (pllclk),
		.reset    (reset),
		.smp      (smp),
		.clr_acc  (clr_acc),
		.wins     (wins),
		.line_cfg (line_cfg),
		.accs     (accs)
	);

	integration_dump u_dump (
		.pllclk      (pllclk),
		.reset       (reset),
		.dump        (dump),
		.accs        (accs),
		.clr_acc     (clr_acc),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

endmodule

// File: test/tb_checks.svh
// Frame checks for the correlator testbench
// Error-line helper and concurrent assertions against the model frame

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic value_mismatch(input string name, input int expected, input int actual);
	$display("** Error at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	errors++;
endtask

task automatic check_field(input string name, input int expected, input int actual);
	assert (expected == actual)
	else value_mismatch(name, expected, actual);
endtask

// ********************************************************************
// Frame against model, sampled mid-cycle
// ********************************************************************

// One cycle of frame_valid per dump
assert property (@(negedge pllclk) disable iff (!reset) frame_valid == x_valid)
else value_mismatch("frame_valid", int'(x_valid), int'(frame_valid));

for (genvar b = 0; b < `NUM_BASELINES; b++) begin : g_base_chk
	assert property (@(negedge pllclk) disable iff (!reset)
		frame_valid |-> int'(frame[b].overflow) == int'(x_ovf[b]))
	else value_mismatch($sformatf("frame[%0d].overflow", b), int'(x_ovf[b]),
		int'(frame[b].overflow));

	for (genvar k = 0; k < `NUM_LAGS; k++) begin : g_lag_chk
		assert property (@(negedge pllclk) disable iff (!reset)
			frame_valid |-> int'(frame[b].lags[k].re) == x_acc[b][k][0])
		else value_mismatch($sformatf("frame[%0d].lags[%0d].re", b, k), x_acc[b][k][0],
			int'(frame[b].lags[k].re));

		assert property (@(negedge pllclk) disable iff (!reset)
			frame_valid |-> int'(frame[b].lags[k].im) == x_acc[b][k][1])
		else value_mismatch($sformatf("frame[%0d].lags[%0d].im", b, k), x_acc[b][k][1],
			int'(frame[b].lags[k].im));
	end
end

`endif

// File: test/tb_correlator.sv
// Correlator testbench
// Drives sample streams and dumps, tracks a cycle model of the correlator

`include "correlator_config.svh"

module tb_correlator;

	localparam int MAX_CYCLES = 4000;
	localparam int LIMIT = 2 ** (`RESOLUTION - 1) - 1 - 2 ** (2 * `WORD_WIDTH);

	logic                                        pllclk = 1'b0;
	logic                                        reset;
	logic                                        smp;
	logic                                        dump;
	correlator_pkg::sample_t   [`NUM_INPUTS-1:0] samples;
	correlator_pkg::line_cfg_t [`NUM_INPUTS-1:0] line_cfg;
	correlator_pkg::frame_t                      frame;
	logic                                        frame_valid;

	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;

	// Model state with re at last index 0 and im at 1
	int m_hist [`NUM_INPUTS][`HIST_DEPTH];
	int m_acc  [`NUM_BASELINES][`NUM_LAGS][2];
	bit m_ovf  [`NUM_BASELINES];
	bit m_add_en;
	int x_acc  [`NUM_BASELINES][`NUM_LAGS][2];   // Expected frame
	bit x_ovf  [`NUM_BASELINES];
	bit x_valid;

	correlator_top dut_i (
		.pllclk      (pllclk),
		.reset       (reset),
		.smp         (smp),
		.samples     (samples),
		.line_cfg    (line_cfg),
		.dump        (dump),
		.frame       (frame),
		.frame_valid (frame_valid)
	);

	`include "tb_checks.svh"

	initial begin
		forever #2 pllclk = ~pllclk;
	end

	always @(posedge pllclk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ********************************************************************
	// Reference model
	// ********************************************************************

	task automatic update_baseline(input int idx, input int a, input int b);
		int da;
		int db;
		int tap_a;
		int tap_b;
		int term [`NUM_LAGS][2];
		bit near;
		bit diff;
		da = int'(line_cfg[a].delay);
		db = int'(line_cfg[b].delay);
		diff = line_cfg[a].mode && line_cfg[b].mode;
		near = 1'b0;
		for (int k = 0; k < `NUM_LAGS; k++) begin
			for (int w = 0; w < 2; w++) begin
				tap_a = m_hist[a][da + k + w];
				tap_b = m_hist[b][db + 1 + w];   // Centre tap of line b
				term[k][w] = diff ? tap_a - tap_b : tap_a * tap_b;
				if (m_acc[idx][k][w] >= LIMIT || m_acc[idx][k][w] <= -LIMIT)
					near = 1'b1;
			end
		end
		if (dump) begin
			m_ovf[idx] = 1'b0;
			for (int k = 0; k < `NUM_LAGS; k++)
				for (int w = 0; w < 2; w++)
					m_acc[idx][k][w] = m_add_en ? term[k][w] : 0;
		end else if (m_add_en) begin
			if (m_ovf[idx] || near) begin
				m_ovf[idx] = 1'b1;
			end else begin
				for (int k = 0; k < `NUM_LAGS; k++)
					for (int w = 0; w < 2; w++)
						m_acc[idx][k][w] += term[k][w];
			end
		end
	endtask

	always @(posedge pllclk) begin : model
		int idx;
		if (!reset) begin
			m_hist = '{default: 0};
			m_acc = '{default: 0};
			m_ovf = '{default: 0};
			x_acc = '{default: 0};
			x_ovf = '{default: 0};
			m_add_en = 1'b0;
			x_valid = 1'b0;
		end else begin
			if (dump) begin                  // Snapshot before this edge's adds
				x_acc = m_acc;
				x_ovf = m_ovf;
			end
			x_valid = dump;
			idx = 0;
			for (int a = 0; a < `NUM_INPUTS - 1; a++) begin
				for (int b = a + 1; b < `NUM_INPUTS; b++) begin
					update_baseline(idx, a, b);
					idx++;
				end
			end
			if (smp) begin
				for (int l = 0; l < `NUM_INPUTS; l++) begin
					for (int i = `HIST_DEPTH - 1; i > 0; i--)
						m_hist[l][i] = m_hist[l][i-1];
					m_hist[l][0] = int'($signed(samples[l]));
				end
			end
			m_add_en = smp;
		end
	end

	// ********************************************************************
	// Stimulus helpers
	// ********************************************************************

	task automatic cycle_inputs(input bit strobe, input bit dump_now);
		smp = strobe;
		dump = dump_now;
		@(negedge pllclk);
		smp = 1'b0;
		dump = 1'b0;
	endtask

	task automatic configure(input logic [`DELAY_WIDTH*`NUM_INPUTS-1:0] delays,
			input logic [`NUM_INPUTS-1:0] modes);
		for (int i = 0; i < `NUM_INPUTS; i++) begin
			line_cfg[i].delay = delays[`DELAY_WIDTH*i +: `DELAY_WIDTH];
			line_cfg[i].mode = modes[i];
		end
	endtask

	task automatic random_samples();
		for (int i = 0; i < `NUM_INPUTS; i++)
			samples[i] = correlator_pkg::sample_t'($urandom_range(3, 0));
	endtask

	task automatic dump_and_wait();
		cycle_inputs(1'b0, 1'b1);
		while (!frame_valid)
			@(negedge pllclk);
		repeat (2) @(negedge pllclk);        // Frame and frame_valid drop checked
	endtask

	task automatic random_run(input int count);
		for (int n = 0; n < count; n++) begin
			random_samples();
			cycle_inputs(1'b1, 1'b0);
			if ($urandom_range(1, 0) == 1)
				cycle_inputs(1'b0, 1'b0);
		end
		repeat (2) cycle_inputs(1'b0, 1'b0);
	endtask

	task automatic check_frame_zero();
		check_field("frame_valid", 0, int'(frame_valid));
		for (int b = 0; b < `NUM_BASELINES; b++) begin
			check_field($sformatf("frame[%0d].overflow", b), 0, int'(frame[b].overflow));
			for (int k = 0; k < `NUM_LAGS; k++) begin
				check_field($sformatf("frame[%0d].lags[%0d].re", b, k), 0,
					int'(frame[b].lags[k].re));
				check_field($sformatf("frame[%0d].lags[%0d].im", b, k), 0,
					int'(frame[b].lags[k].im));
			end
		end
	endtask

	task automatic check_overflow_bits(input int expected);
		for (int b = 0; b < `NUM_BASELINES; b++)
			check_field($sformatf("frame[%0d].overflow", b), expected, int'(frame[b].overflow));
	endtask

	task automatic record_result(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	// ********************************************************************
	// Test sequence
	// ********************************************************************

	initial begin
		int start;
		void'($urandom(32'ha992_c9e2));
		reset = 1'b0;
		smp = 1'b0;
		dump = 1'b0;
		samples = '0;
		line_cfg = '0;
		repeat (4) @(negedge pllclk);
		reset = 1'b1;

		start = errors;
		repeat (3) begin
			@(negedge pllclk);
			check_frame_zero();
		end
		dump_and_wait();
		check_frame_zero();
		record_result("reset state and empty dump", start);

		start = errors;
		configure('0, '0);
		dump_and_wait();
		random_run(20);
		dump_and_wait();
		record_result("random product frame", start);

		// Impulse on line 0 against a constant line 1 at offsets 3 and 1
		start = errors;
		configure({3'd6, 3'd5, 3'd1, 3'd3}, 4'b0000);
		samples = '0;
		samples[1] = correlator_pkg::sample_t'(1);
		repeat (12) cycle_inputs(1'b1, 1'b0);
		cycle_inputs(1'b0, 1'b0);
		dump_and_wait();
		samples[0] = correlator_pkg::sample_t'(-2);
		cycle_inputs(1'b1, 1'b0);
		samples[0] = '0;
		repeat (4) cycle_inputs(1'b1, 1'b0);
		repeat (2) cycle_inputs(1'b0, 1'b0);
		dump_and_wait();
		// Tap 3 feeds re lag 0, then tap 4 feeds re lag 1 and im lag 0
		for (int b = 0; b < `NUM_BASELINES; b++) begin
			for (int k = 0; k < `NUM_LAGS; k++) begin
				check_field($sformatf("frame[%0d].lags[%0d].re", b, k),
					(b == 0 && k < 2) ? -2 : 0, int'(frame[b].lags[k].re));
				check_field($sformatf("frame[%0d].lags[%0d].im", b, k),
					(b == 0 && k == 0) ? -2 : 0, int'(frame[b].lags[k].im));
			end
		end
		record_result("lag and quadrature placement", start);

		start = errors;
		configure({3'd3, 3'd0, 3'd2, 3'd1}, 4'b0011);
		dump_and_wait();
		random_run(20);
		dump_and_wait();
		record_result("difference mode on lines 0 and 1", start);

		// Full-scale products of 4 run every baseline into its limit
		start = errors;
		configure('0, '0);
		dump_and_wait();
		for (int i = 0; i < `NUM_INPUTS; i++)
			samples[i] = correlator_pkg::sample_t'(-2);
		repeat (300) cycle_inputs(1'b1, 1'b0);
		samples = '0;
		repeat (2) cycle_inputs(1'b0, 1'b0);
		dump_and_wait();
		check_overflow_bits(1);
		dump_and_wait();
		check_overflow_bits(0);
		record_result("overflow freeze and clear", start);

		// Dumps land among back-to-back strobes and once right after the last one
		start = errors;
		configure({3'd3, 3'd1, 3'd0, 3'd2}, 4'b0101);
		dump_and_wait();
		for (int c = 0; c < 40; c++) begin
			random_samples();
			cycle_inputs(1'b1, (c == 6 || c == 13 || c == 29));
		end
		dump_and_wait();
		repeat (2) cycle_inputs(1'b0, 1'b0);
		dump_and_wait();
		record_result("back-to-back integration", start);

		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+common
+incdir+test
common/correlator_pkg.sv
src/delay_line.sv
correlator/baseline_mac.sv
correlator/correlator_array.sv
src/integration_dump.sv
src/correlator_top.sv
test/tb_correlator.sv

// File: run.sh
#!/bin/sh
# Build the correlator testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	-f build.f \
	--top-module tb_correlator

./obj_dir/Vtb_correlator > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
